/* Makefile */
SIM      := verilator
TOP      := tb_cache_ctrl
FILELIST := cache_ctrl.f
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* cache_ctrl.f */
cache_ctrl_pkg.sv
cache_ctrl_if.sv
ctrl_fwd_decode.sv
ctrl_bank_issue.sv
ctrl_resp_track.sv
ctrl_resp_pack.sv
cache_ctrl_top.sv
tb_cache_ctrl_props.sv
tb_cache_ctrl.sv

/* cache_ctrl_if.sv */
// cache_req_if and resp_track_if interfaces with their modports
`timescale 1ns/1ps
`default_nettype none

// decoded request from the decode register to the bank issue stage
interface cache_req_if;
  cache_ctrl_pkg::mem_hdr_s                  hdr;
  cache_ctrl_pkg::cache_op_e                 op;
  logic [cache_ctrl_pkg::bank_sel_width-1:0] bank;
  logic [cache_ctrl_pkg::addr_width-1:0]     bank_addr;
  logic [cache_ctrl_pkg::data_width-1:0]     data;
  logic                                      valid;
  logic                                      ready;

  modport producer (
    output hdr, op, bank, bank_addr, data, valid,
    input  ready
  );

  modport consumer (
    input  hdr, op, bank, bank_addr, data, valid,
    output ready
  );
endinterface

// head entry of the response tracking FIFO
interface resp_track_if;
  cache_ctrl_pkg::mem_hdr_s                  hdr;
  logic [cache_ctrl_pkg::bank_sel_width-1:0] bank;
  logic                                      valid;
  logic                                      pop;

  modport source (
    output hdr, bank, valid,
    input  pop
  );

  modport sink (
    input  hdr, bank, valid,
    output pop
  );
endinterface

`default_nettype wire

/* cache_ctrl_pkg.sv */
// sizes, enums and the request header type shared by the cache controller
`default_nettype none

package cache_ctrl_pkg;

  // data path and address sizes
  localparam int data_width = 64;
  localparam int data_bytes = data_width / 8;
  localparam int addr_width = 28;

  // cache bank organization
  localparam int num_banks          = 2;
  localparam int bank_sel_width     = 1;
  localparam int l2_sets            = 8;
  localparam int l2_assoc           = 2;
  localparam int blocks_per_bank    = l2_sets * l2_assoc;
  localparam int block_offset_width = 6;

  // room for three outstanding requests per bank
  localparam int track_depth = num_banks * 3;
  localparam int id_width    = 4;

  typedef enum logic {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } msg_type_e;

  // encoded as log2 of the byte count
  typedef enum logic [1:0] {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2,
    e_size_8 = 2'd3
  } msg_size_e;

  typedef enum logic [3:0] {
    e_op_tagst = 4'd0,
    e_op_lb    = 4'd1,
    e_op_lh    = 4'd2,
    e_op_lw    = 4'd3,
    e_op_ld    = 4'd4,
    e_op_sb    = 4'd5,
    e_op_sh    = 4'd6,
    e_op_sw    = 4'd7,
    e_op_sd    = 4'd8
  } cache_op_e;

  typedef enum logic [1:0] {
    e_init_reset = 2'd0,
    e_init_clear = 2'd1,
    e_init_ready = 2'd2
  } init_state_e;

  typedef struct packed {
    msg_type_e             msg_type;
    msg_size_e             size;
    logic [addr_width-1:0] addr;
    logic [id_width-1:0]   id;
  } mem_hdr_s;

endpackage

`default_nettype wire

/* cache_ctrl_top.sv */
// cache controller top level with decode, issue, tracking and response stages
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl_top (
  input  logic                                                            clk_i,
  input  logic                                                            reset_i,
  input  cache_ctrl_pkg::msg_type_e                                       fwd_type_i,
  input  cache_ctrl_pkg::msg_size_e                                       fwd_size_i,
  input  logic [cache_ctrl_pkg::addr_width-1:0]                           fwd_addr_i,
  input  logic [cache_ctrl_pkg::id_width-1:0]                             fwd_id_i,
  input  logic [cache_ctrl_pkg::data_width-1:0]                           fwd_data_i,
  input  logic                                                            fwd_v_i,
  output logic                                                            fwd_ready_o,
  output cache_ctrl_pkg::msg_type_e                                       rev_type_o,
  output cache_ctrl_pkg::msg_size_e                                       rev_size_o,
  output logic [cache_ctrl_pkg::addr_width-1:0]                           rev_addr_o,
  output logic [cache_ctrl_pkg::id_width-1:0]                             rev_id_o,
  output logic [cache_ctrl_pkg::data_width-1:0]                           rev_data_o,
  output logic                                                            rev_v_o,
  input  logic                                                            rev_ready_i,
  output cache_ctrl_pkg::cache_op_e                                       cache_op_o,
  output logic [cache_ctrl_pkg::addr_width-1:0]                           cache_addr_o,
  output logic [cache_ctrl_pkg::data_width-1:0]                           cache_data_o,
  output logic [cache_ctrl_pkg::num_banks-1:0]                            cache_pkt_v_o,
  input  logic [cache_ctrl_pkg::num_banks-1:0]                            cache_pkt_yumi_i,
  input  logic [cache_ctrl_pkg::num_banks-1:0][cache_ctrl_pkg::data_width-1:0] cache_data_i,
  input  logic [cache_ctrl_pkg::num_banks-1:0]                            cache_data_v_i,
  output logic [cache_ctrl_pkg::num_banks-1:0]                            cache_data_yumi_o
);

  cache_req_if  req_bus ();
  resp_track_if trk_bus ();

  logic                                      trk_push;
  cache_ctrl_pkg::mem_hdr_s                  trk_hdr;
  logic [cache_ctrl_pkg::bank_sel_width-1:0] trk_bank;
  logic                                      trk_full;
  logic [cache_ctrl_pkg::num_banks-1:0]      init_data_yumi;
  logic [cache_ctrl_pkg::num_banks-1:0]      pack_data_yumi;

  ctrl_fwd_decode u_decode (
    .clk_i, .reset_i, .fwd_type_i, .fwd_size_i, .fwd_addr_i, .fwd_id_i, .fwd_data_i,
    .fwd_v_i, .fwd_ready_o, .req(req_bus.producer)
  );

  ctrl_bank_issue u_issue (
    .clk_i, .reset_i, .req(req_bus.consumer), .cache_op_o, .cache_addr_o, .cache_data_o,
    .cache_pkt_v_o, .cache_data_yumi_o(init_data_yumi), .cache_pkt_yumi_i, .cache_data_v_i,
    .trk_push_o(trk_push), .trk_hdr_o(trk_hdr), .trk_bank_o(trk_bank), .trk_full_i(trk_full)
  );

  ctrl_resp_track u_track (
    .clk_i, .reset_i, .push_i(trk_push), .hdr_i(trk_hdr), .bank_i(trk_bank),
    .full_o(trk_full), .head(trk_bus.source)
  );

  ctrl_resp_pack u_pack (
    .clk_i, .reset_i, .head(trk_bus.sink), .cache_data_i, .cache_data_v_i,
    .pack_data_yumi_o(pack_data_yumi), .rev_type_o, .rev_size_o, .rev_addr_o, .rev_id_o,
    .rev_data_o, .rev_v_o, .rev_ready_i
  );

  // init drains clears and the packer drains responses, never both at once
  assign cache_data_yumi_o = init_data_yumi | pack_data_yumi;

endmodule

`default_nettype wire

/* ctrl_bank_issue.sv */
// tag clear init sequence and per-bank cache packet issue
`timescale 1ns/1ps
`default_nettype none

module ctrl_bank_issue (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  cache_req_if.consumer                             req,
  output cache_ctrl_pkg::cache_op_e                 cache_op_o,
  output logic [cache_ctrl_pkg::addr_width-1:0]     cache_addr_o,
  output logic [cache_ctrl_pkg::data_width-1:0]     cache_data_o,
  output logic [cache_ctrl_pkg::num_banks-1:0]      cache_pkt_v_o,
  output logic [cache_ctrl_pkg::num_banks-1:0]      cache_data_yumi_o,
  input  logic [cache_ctrl_pkg::num_banks-1:0]      cache_pkt_yumi_i,
  input  logic [cache_ctrl_pkg::num_banks-1:0]      cache_data_v_i,
  output logic                                      trk_push_o,
  output cache_ctrl_pkg::mem_hdr_s                  trk_hdr_o,
  output logic [cache_ctrl_pkg::bank_sel_width-1:0] trk_bank_o,
  input  logic                                      trk_full_i
);

  typedef logic [$clog2(cache_ctrl_pkg::num_banks * cache_ctrl_pkg::blocks_per_bank):0] clr_cnt_t;

  localparam clr_cnt_t clr_total = clr_cnt_t'(cache_ctrl_pkg::num_banks *
                                              cache_ctrl_pkg::blocks_per_bank);
  localparam int idx_width = $clog2(cache_ctrl_pkg::blocks_per_bank);

  cache_ctrl_pkg::init_state_e state_r;
  clr_cnt_t sent_r;
  clr_cnt_t recv_r;
  clr_cnt_t recv_inc;
  logic [cache_ctrl_pkg::bank_sel_width-1:0] clr_bank;
  logic is_clear;
  logic is_ready;

  assign is_clear = (state_r == cache_ctrl_pkg::e_init_clear);
  assign is_ready = (state_r == cache_ctrl_pkg::e_init_ready);
  // clears run through bank 0 before bank 1
  assign clr_bank = sent_r[idx_width +: cache_ctrl_pkg::bank_sel_width];

  always_comb
  begin
    cache_op_o    = req.op;
    cache_addr_o  = req.bank_addr;
    cache_data_o  = req.data;
    cache_pkt_v_o = '0;
    if (is_clear)
    begin
      cache_op_o   = cache_ctrl_pkg::e_op_tagst;
      cache_addr_o = cache_ctrl_pkg::addr_width'(sent_r[idx_width-1:0])
                     << cache_ctrl_pkg::block_offset_width;
      cache_data_o = '0;
      if (sent_r < clr_total)
        cache_pkt_v_o[clr_bank] = 1'b1;
    end
    else if (is_ready)
      cache_pkt_v_o[req.bank] = req.valid & ~trk_full_i;
  end

  // with no item held, ready only reflects room downstream
  assign req.ready = is_ready & ~trk_full_i & (~req.valid | cache_pkt_yumi_i[req.bank]);

  assign trk_push_o = is_ready & req.valid & cache_pkt_yumi_i[req.bank];
  assign trk_hdr_o  = req.hdr;
  assign trk_bank_o = req.bank;

  // tag clear responses carry nothing useful, drain them all
  assign cache_data_yumi_o = is_clear ? cache_data_v_i : '0;

  always_comb
  begin
    recv_inc = '0;
    for (int b = 0; b < cache_ctrl_pkg::num_banks; b++)
      recv_inc = recv_inc + clr_cnt_t'(cache_data_yumi_o[b]);
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= cache_ctrl_pkg::e_init_reset;
      sent_r  <= '0;
      recv_r  <= '0;
    end
    else
    begin
      case (state_r)
        cache_ctrl_pkg::e_init_reset:
          state_r <= cache_ctrl_pkg::e_init_clear;
        cache_ctrl_pkg::e_init_clear:
        begin
          if (|cache_pkt_yumi_i)
            sent_r <= sent_r + 1'b1;
          recv_r <= recv_r + recv_inc;
          if (sent_r == clr_total && recv_r == clr_total)
            state_r <= cache_ctrl_pkg::e_init_ready;
        end
        default:
          state_r <= state_r;
      endcase
    end
  end

endmodule

`default_nettype wire

/* ctrl_fwd_decode.sv */
// request decode register with opcode mapping and bank address swizzle
`timescale 1ns/1ps
`default_nettype none

module ctrl_fwd_decode (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  cache_ctrl_pkg::msg_type_e             fwd_type_i,
  input  cache_ctrl_pkg::msg_size_e             fwd_size_i,
  input  logic [cache_ctrl_pkg::addr_width-1:0] fwd_addr_i,
  input  logic [cache_ctrl_pkg::id_width-1:0]   fwd_id_i,
  input  logic [cache_ctrl_pkg::data_width-1:0] fwd_data_i,
  input  logic                                  fwd_v_i,
  output logic                                  fwd_ready_o,
  cache_req_if.producer                         req
);

  cache_ctrl_pkg::cache_op_e             op_n;
  logic [cache_ctrl_pkg::addr_width-1:0] bank_addr_n;
  logic                                  take;

  // consumer ready is low through init and while the held item is stalled
  assign fwd_ready_o = req.ready;
  assign take        = fwd_v_i & fwd_ready_o;

  always_comb
  begin
    case (fwd_size_i)
      cache_ctrl_pkg::e_size_1: op_n = cache_ctrl_pkg::e_op_lb;
      cache_ctrl_pkg::e_size_2: op_n = cache_ctrl_pkg::e_op_lh;
      cache_ctrl_pkg::e_size_4: op_n = cache_ctrl_pkg::e_op_lw;
      default:                  op_n = cache_ctrl_pkg::e_op_ld;
    endcase
    // stores sit four codes above the matching loads
    if (fwd_type_i == cache_ctrl_pkg::e_mem_wr)
      op_n = cache_ctrl_pkg::cache_op_e'(op_n + 4'd4);
  end

  // drop the bank select bit and close the gap from above
  assign bank_addr_n = {1'b0,
                        fwd_addr_i[cache_ctrl_pkg::addr_width-1:
                                   cache_ctrl_pkg::block_offset_width+1],
                        fwd_addr_i[cache_ctrl_pkg::block_offset_width-1:0]};

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      req.valid <= 1'b0;
    else if (take)
      req.valid <= 1'b1;
    else if (req.ready)
      req.valid <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      req.hdr       <= '{msg_type: fwd_type_i, size: fwd_size_i,
                         addr: fwd_addr_i, id: fwd_id_i};
      req.op        <= op_n;
      req.bank      <= fwd_addr_i[cache_ctrl_pkg::block_offset_width];
      req.bank_addr <= bank_addr_n;
      req.data      <= fwd_data_i;
    end
  end

endmodule

`default_nettype wire

/* ctrl_resp_pack.sv */
// bank data select, size masking and registered response output
`timescale 1ns/1ps
`default_nettype none

module ctrl_resp_pack (
  input  logic                                                            clk_i,
  input  logic                                                            reset_i,
  resp_track_if.sink                                                      head,
  input  logic [cache_ctrl_pkg::num_banks-1:0][cache_ctrl_pkg::data_width-1:0] cache_data_i,
  input  logic [cache_ctrl_pkg::num_banks-1:0]                            cache_data_v_i,
  output logic [cache_ctrl_pkg::num_banks-1:0]                            pack_data_yumi_o,
  output cache_ctrl_pkg::msg_type_e                                       rev_type_o,
  output cache_ctrl_pkg::msg_size_e                                       rev_size_o,
  output logic [cache_ctrl_pkg::addr_width-1:0]                           rev_addr_o,
  output logic [cache_ctrl_pkg::id_width-1:0]                             rev_id_o,
  output logic [cache_ctrl_pkg::data_width-1:0]                           rev_data_o,
  output logic                                                            rev_v_o,
  input  logic                                                            rev_ready_i
);

  logic [cache_ctrl_pkg::data_width-1:0] sel_data;
  logic [cache_ctrl_pkg::data_width-1:0] masked_data;
  logic                                  take;

  // bank data is aligned at the LSB, keep only the requested bytes
  assign sel_data = cache_data_i[head.bank];

  always_comb
  begin
    masked_data = '0;
    for (int i = 0; i < cache_ctrl_pkg::data_bytes; i++)
    begin
      if (i < (1 << head.hdr.size))
        masked_data[8*i +: 8] = sel_data[8*i +: 8];
    end
  end

  // take data only when the output register is free this edge
  assign take     = head.valid & cache_data_v_i[head.bank] & (~rev_v_o | rev_ready_i);
  assign head.pop = take;

  always_comb
  begin
    pack_data_yumi_o            = '0;
    pack_data_yumi_o[head.bank] = take;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      rev_v_o <= 1'b0;
    else if (take)
      rev_v_o <= 1'b1;
    else if (rev_ready_i)
      rev_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      rev_type_o <= head.hdr.msg_type;
      rev_size_o <= head.hdr.size;
      rev_addr_o <= head.hdr.addr;
      rev_id_o   <= head.hdr.id;
      rev_data_o <= masked_data;
    end
  end

endmodule

`default_nettype wire

/* ctrl_resp_track.sv */
// in-order tracking FIFO of bank and header for requests in flight
`timescale 1ns/1ps
`default_nettype none

module ctrl_resp_track (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      push_i,
  input  cache_ctrl_pkg::mem_hdr_s                  hdr_i,
  input  logic [cache_ctrl_pkg::bank_sel_width-1:0] bank_i,
  output logic                                      full_o,
  resp_track_if.source                              head
);

  localparam int ptr_width = $clog2(cache_ctrl_pkg::track_depth);
  localparam int cnt_width = $clog2(cache_ctrl_pkg::track_depth + 1);

  cache_ctrl_pkg::mem_hdr_s                  hdr_mem  [cache_ctrl_pkg::track_depth];
  logic [cache_ctrl_pkg::bank_sel_width-1:0] bank_mem [cache_ctrl_pkg::track_depth];
  logic [ptr_width-1:0] wr_ptr_r;
  logic [ptr_width-1:0] rd_ptr_r;
  logic [cnt_width-1:0] count_r;

  assign full_o     = (count_r == cnt_width'(cache_ctrl_pkg::track_depth));
  assign head.valid = (count_r != '0);
  assign head.hdr   = hdr_mem[rd_ptr_r];
  assign head.bank  = bank_mem[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (push_i)
    begin
      hdr_mem[wr_ptr_r]  <= hdr_i;
      bank_mem[wr_ptr_r] <= bank_i;
    end
  end

  // depth is not a power of two so pointers wrap by compare
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_r <= (wr_ptr_r == ptr_width'(cache_ctrl_pkg::track_depth - 1)) ? '0
                                                                               : wr_ptr_r + 1'b1;
      if (head.pop)
        rd_ptr_r <= (rd_ptr_r == ptr_width'(cache_ctrl_pkg::track_depth - 1)) ? '0
                                                                               : rd_ptr_r + 1'b1;
      if (push_i && !head.pop)
        count_r <= count_r + 1'b1;
      else if (!push_i && head.pop)
        count_r <= count_r - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* tb_cache_ctrl.sv */
// testbench with clock, xorshift stimulus, cache bank models, reference model and compare tasks
`timescale 1ns/1ps
`default_nettype none

module tb_cache_ctrl;

  localparam int clk_period   = 100;
  localparam int num_reqs     = 300;
  localparam int init_timeout = 400;
  localparam int run_timeout  = 20000;
  localparam int off          = cache_ctrl_pkg::block_offset_width;

  typedef logic [cache_ctrl_pkg::bank_sel_width-1:0] bank_t;
  typedef logic [cache_ctrl_pkg::addr_width-1:0]     addr_t;
  typedef logic [cache_ctrl_pkg::data_width-1:0]     data_t;

  logic                                       clk_i;
  logic                                       reset_i;
  cache_ctrl_pkg::msg_type_e                  fwd_type_i;
  cache_ctrl_pkg::msg_size_e                  fwd_size_i;
  addr_t                                      fwd_addr_i;
  logic [cache_ctrl_pkg::id_width-1:0]        fwd_id_i;
  data_t                                      fwd_data_i;
  logic                                       fwd_v_i;
  logic                                       fwd_ready_o;
  cache_ctrl_pkg::msg_type_e                  rev_type_o;
  cache_ctrl_pkg::msg_size_e                  rev_size_o;
  addr_t                                      rev_addr_o;
  logic [cache_ctrl_pkg::id_width-1:0]        rev_id_o;
  data_t                                      rev_data_o;
  logic                                       rev_v_o;
  logic                                       rev_ready_i;
  cache_ctrl_pkg::cache_op_e                  cache_op_o;
  addr_t                                      cache_addr_o;
  data_t                                      cache_data_o;
  logic [cache_ctrl_pkg::num_banks-1:0]       cache_pkt_v_o;
  logic [cache_ctrl_pkg::num_banks-1:0]       cache_pkt_yumi_i;
  logic [cache_ctrl_pkg::num_banks-1:0][63:0] cache_data_i;
  logic [cache_ctrl_pkg::num_banks-1:0]       cache_data_v_i;
  logic [cache_ctrl_pkg::num_banks-1:0]       cache_data_yumi_o;

  // bank models and the reference memory, keyed by bank address and request address
  logic [31:0] rng = 32'd93978;
  logic [7:0]  bank_mem [2][256];
  logic [7:0]  ref_mem [512];
  data_t       rsp_q [2][$];
  int          rsp_wait [2];
  cache_ctrl_pkg::cache_op_e exp_op_q [$];
  bank_t                     exp_bank_q [$];
  addr_t                     exp_baddr_q [$];
  data_t                     exp_pdata_q [$];
  cache_ctrl_pkg::mem_hdr_s  exp_hdr_q [$];
  data_t                     exp_rdata_q [$];
  int   clr_idx = 0;
  int   gen_cnt = 0;
  int   resp_cnt = 0;
  logic init_done = 1'b0;
  logic req_taken = 1'b0;

  cache_ctrl_top dut (.*);

  bind ctrl_bank_issue tb_cache_ctrl_props u_props (
    .clk_i(clk_i), .reset_i(reset_i), .pkt_v_i(cache_pkt_v_o), .trk_full_i(trk_full_i),
    .req_valid_i(req.valid), .req_ready_i(req.ready), .req_hdr_i(req.hdr),
    .req_op_i(req.op), .req_data_i(req.data)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] rand32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // every address bit takes part in the fill byte
  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a * 37 + (a >> 8) + 'h5a);
  endfunction

  function automatic cache_ctrl_pkg::cache_op_e expected_op(
    input cache_ctrl_pkg::msg_type_e t,
    input cache_ctrl_pkg::msg_size_e s
  );
    cache_ctrl_pkg::cache_op_e op;
    if (t == cache_ctrl_pkg::e_mem_rd)
      case (s)
        cache_ctrl_pkg::e_size_1: op = cache_ctrl_pkg::e_op_lb;
        cache_ctrl_pkg::e_size_2: op = cache_ctrl_pkg::e_op_lh;
        cache_ctrl_pkg::e_size_4: op = cache_ctrl_pkg::e_op_lw;
        default:                  op = cache_ctrl_pkg::e_op_ld;
      endcase
    else
      case (s)
        cache_ctrl_pkg::e_size_1: op = cache_ctrl_pkg::e_op_sb;
        cache_ctrl_pkg::e_size_2: op = cache_ctrl_pkg::e_op_sh;
        cache_ctrl_pkg::e_size_4: op = cache_ctrl_pkg::e_op_sw;
        default:                  op = cache_ctrl_pkg::e_op_sd;
      endcase
    return op;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_op(input string name, input cache_ctrl_pkg::cache_op_e got, exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_bank(input string name, input bank_t got, exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input addr_t got, exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_data(input string name, input data_t got, exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_hdr(input string name, input cache_ctrl_pkg::mem_hdr_s got, exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  // bank side of a packet taken at the coming edge
  task automatic take_packet(input int b);
    data_t word;
    int    n;
    word = '0;
    if (!init_done)
    begin
      if (clr_idx >= 2 * cache_ctrl_pkg::blocks_per_bank)
        stop_on_error("more tag clears than the banks hold");
      check_op("cache_op_o", cache_op_o, cache_ctrl_pkg::e_op_tagst);
      check_bank("cache_pkt_v_o bank", bank_t'(b),
                 bank_t'(clr_idx / cache_ctrl_pkg::blocks_per_bank));
      check_addr("cache_addr_o", cache_addr_o,
                 addr_t'(clr_idx % cache_ctrl_pkg::blocks_per_bank) << off);
      check_data("cache_data_o", cache_data_o, '0);
      clr_idx++;
    end
    else if (exp_op_q.size() == 0)
      stop_on_error("bank packet issued with no request pending");
    else
    begin
      check_op("cache_op_o", cache_op_o, exp_op_q.pop_front());
      check_bank("cache_pkt_v_o bank", bank_t'(b), exp_bank_q.pop_front());
      check_addr("cache_addr_o", cache_addr_o, exp_baddr_q.pop_front());
      check_data("cache_data_o", cache_data_o, exp_pdata_q.pop_front());
      case (cache_op_o)
        cache_ctrl_pkg::e_op_lb, cache_ctrl_pkg::e_op_sb: n = 1;
        cache_ctrl_pkg::e_op_lh, cache_ctrl_pkg::e_op_sh: n = 2;
        cache_ctrl_pkg::e_op_lw, cache_ctrl_pkg::e_op_sw: n = 4;
        default:                                          n = 8;
      endcase
      // loads carry junk above the requested bytes
      word = {rand32(), rand32()};
      for (int i = 0; i < n; i++)
      begin
        if (cache_op_o >= cache_ctrl_pkg::e_op_sb)
          bank_mem[b][int'(cache_addr_o) + i] = cache_data_o[8*i +: 8];
        else
          word[8*i +: 8] = bank_mem[b][int'(cache_addr_o) + i];
      end
      if (cache_op_o >= cache_ctrl_pkg::e_op_sb)
        word = '0;
    end
    if (rsp_q[b].size() == 0)
      rsp_wait[b] = int'(rand32() % 4);
    rsp_q[b].push_back(word);
  endtask

  task automatic accept_request();
    cache_ctrl_pkg::mem_hdr_s hdr;
    data_t rdata;
    rdata = '0;
    for (int i = 0; i < (1 << int'(fwd_size_i)); i++)
    begin
      if (fwd_type_i == cache_ctrl_pkg::e_mem_wr)
        ref_mem[int'(fwd_addr_i) + i] = fwd_data_i[8*i +: 8];
      else
        rdata[8*i +: 8] = ref_mem[int'(fwd_addr_i) + i];
    end
    hdr = '{msg_type: fwd_type_i, size: fwd_size_i, addr: fwd_addr_i, id: fwd_id_i};
    exp_op_q.push_back(expected_op(fwd_type_i, fwd_size_i));
    exp_bank_q.push_back(fwd_addr_i[off]);
    // block number halves, the offset inside the block stays
    exp_baddr_q.push_back(((fwd_addr_i >> (off + 1)) << off)
                          | (fwd_addr_i & addr_t'((1 << off) - 1)));
    exp_pdata_q.push_back(fwd_data_i);
    exp_hdr_q.push_back(hdr);
    exp_rdata_q.push_back(rdata);
  endtask

  // sampled mid-cycle, so this is what the next edge will do
  task automatic observe();
    cache_ctrl_pkg::mem_hdr_s got_hdr;
    for (int b = 0; b < cache_ctrl_pkg::num_banks; b++)
    begin
      if (cache_pkt_yumi_i[b])
        take_packet(b);
      if (cache_data_yumi_o[b] && !cache_data_v_i[b])
        stop_on_error("bank data taken while not valid");
      else if (cache_data_yumi_o[b])
      begin
        void'(rsp_q[b].pop_front());
        rsp_wait[b] = int'(rand32() % 4);
      end
    end
    if (rev_v_o && rev_ready_i && exp_hdr_q.size() == 0)
      stop_on_error("response with no request outstanding");
    else if (rev_v_o && rev_ready_i)
    begin
      got_hdr = '{msg_type: rev_type_o, size: rev_size_o, addr: rev_addr_o, id: rev_id_o};
      check_hdr("rev header", got_hdr, exp_hdr_q.pop_front());
      check_data("rev_data_o", rev_data_o, exp_rdata_q.pop_front());
      resp_cnt++;
    end
    if (fwd_ready_o && !init_done)
    begin
      if (clr_idx != 2 * cache_ctrl_pkg::blocks_per_bank || rsp_q[0].size() != 0
          || rsp_q[1].size() != 0)
        stop_on_error("request side opened before all tag clears were acknowledged");
      else
        init_done = 1'b1;
    end
    if (fwd_v_i && fwd_ready_o)
    begin
      accept_request();
      req_taken = 1'b1;
    end
  endtask

  task automatic new_request();
    int a;
    fwd_type_i = cache_ctrl_pkg::msg_type_e'(rand32() % 2);
    fwd_size_i = cache_ctrl_pkg::msg_size_e'(rand32() % 4);
    // small aligned window so loads hit earlier stores
    a = int'(rand32() % 256);
    a = a - (a % (1 << int'(fwd_size_i)));
    fwd_addr_i = addr_t'(a);
    fwd_id_i   = 4'(gen_cnt);
    fwd_data_i = {rand32(), rand32()};
    fwd_v_i    = 1'b1;
    gen_cnt++;
  endtask

  task automatic drive();
    for (int b = 0; b < cache_ctrl_pkg::num_banks; b++)
    begin
      cache_pkt_yumi_i[b] = cache_pkt_v_o[b] && (rand32() % 4 != 0);
      if (rsp_wait[b] > 0)
        rsp_wait[b] = rsp_wait[b] - 1;
      cache_data_v_i[b] = (rsp_q[b].size() != 0) && (rsp_wait[b] == 0);
      cache_data_i[b]   = cache_data_v_i[b] ? rsp_q[b][0] : {rand32(), rand32()};
    end
    rev_ready_i = (rand32() % 3 != 0);
    if (req_taken || !fwd_v_i)
    begin
      fwd_v_i = 1'b0;
      if (gen_cnt < num_reqs && rand32() % 4 != 0)
        new_request();
    end
    req_taken = 1'b0;
  endtask

  task automatic step_cycle();
    @(negedge clk_i);
    observe();
    @(posedge clk_i);
    #1;
    drive();
  endtask

  initial
  begin
    int cycles;
    reset_i          = 1'b1;
    fwd_type_i       = cache_ctrl_pkg::e_mem_rd;
    fwd_size_i       = cache_ctrl_pkg::e_size_1;
    fwd_addr_i       = '0;
    fwd_id_i         = '0;
    fwd_data_i       = '0;
    fwd_v_i          = 1'b0;
    rev_ready_i      = 1'b0;
    cache_pkt_yumi_i = '0;
    cache_data_i     = '0;
    cache_data_v_i   = '0;
    rsp_wait         = '{0, 0};
    for (int a = 0; a < 512; a++)
      ref_mem[a] = fill_byte(a);
    // bank address with the bank bit put back gives the request address
    for (int b = 0; b < 2; b++)
      for (int ba = 0; ba < 256; ba++)
        bank_mem[b][ba] = fill_byte(((ba >> off) << (off + 1)) | (b << off) | (ba % 64));
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    if (fwd_ready_o || rev_v_o || cache_pkt_v_o != '0 || cache_data_yumi_o != '0)
      stop_on_error("outputs not idle during reset");
    @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    cycles = 0;
    while (!init_done)
    begin
      step_cycle();
      cycles++;
      if (cycles > init_timeout)
        stop_on_error("timeout waiting for the tag clear sequence to finish");
    end
    cycles = 0;
    while (resp_cnt < num_reqs)
    begin
      step_cycle();
      cycles++;
      if (cycles > run_timeout)
        stop_on_error("timeout waiting for all responses");
    end
    // a stray packet or response would still be pending here
    @(negedge clk_i);
    if (rev_v_o || cache_pkt_v_o != '0 || !fwd_ready_o)
      stop_on_error("DUT still busy after the last response");
    else
    begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tb_cache_ctrl_props.sv */
// concurrent assertions on the bank issue stage packet and request handshakes
`timescale 1ns/1ps
`default_nettype none

module tb_cache_ctrl_props (
  input logic                                  clk_i,
  input logic                                  reset_i,
  input logic [cache_ctrl_pkg::num_banks-1:0]  pkt_v_i,
  input logic                                  trk_full_i,
  input logic                                  req_valid_i,
  input logic                                  req_ready_i,
  input cache_ctrl_pkg::mem_hdr_s              req_hdr_i,
  input cache_ctrl_pkg::cache_op_e             req_op_i,
  input logic [cache_ctrl_pkg::data_width-1:0] req_data_i
);

  pkt_one_hot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(pkt_v_i))
    else $error("more than one bank packet valid");

  no_issue_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    trk_full_i |-> (pkt_v_i == '0))
    else $error("packet issued while tracking FIFO is full");

  // a held item keeps its valid and its content
  req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (req_valid_i && !req_ready_i) |=>
      (req_valid_i && $stable(req_hdr_i) && $stable(req_op_i) && $stable(req_data_i)))
    else $error("decoded request changed before its transfer");

endmodule

`default_nettype wire
